/* hdl/debug_cmd_pkg.sv */
package debug_cmd_pkg;

    localparam int BYTE_W     = 8;                       // UART byte
    localparam int WORD_W     = 32;                      // Instruction word
    localparam int WORD_BYTES = WORD_W / BYTE_W;         // Bytes per word

    // An all-ones word closes a program load and is never written
    localparam logic [WORD_W-1:0] HALT_WORD = 32'hffff_ffff;

    // One-hot command bytes sent by the host
    typedef enum logic [BYTE_W-1:0] {
        CMD_LOAD      = 8'h01,                           // Receive program words
        CMD_DEBUG     = 8'h02,                           // Enter step mode
        CMD_RUN       = 8'h04,                           // Continuous run
        CMD_STEP      = 8'h08,                           // One step, then dump
        CMD_END_DEBUG = 8'h10                            // Leave step mode with a dump
    } cmd_e;

    typedef enum logic [2:0] {
        ST_IDLE,                                         // Waiting for a command
        ST_LOAD,                                         // Program words arriving
        ST_DEBUG,                                        // Waiting for step or end
        ST_RUN,                                          // Processor running
        ST_DUMP                                          // Snapshot going out
    } ctrl_state_e;

endpackage

/* hdl/pipe_snapshot_pkg.sv */
package pipe_snapshot_pkg;

    localparam int CTRL_W     = 16;                      // 15 control bits, top bit zero
    localparam int SNAP_W     = CTRL_W + 6 * debug_cmd_pkg::WORD_W;
    localparam int SNAP_BYTES = SNAP_W / debug_cmd_pkg::BYTE_W;
    localparam int SNAP_CNT_W = 5;                       // Holds 0 .. SNAP_BYTES-1

    // Control sits on top, the program counter at the bottom.
    // Bytes leave least significant first, so the PC goes out first.
    function automatic logic [SNAP_W-1:0] pack_snapshot(
        input logic [CTRL_W-1:0]                ctrl,
        input logic [debug_cmd_pkg::WORD_W-1:0] mem_addr,
        input logic [debug_cmd_pkg::WORD_W-1:0] mem_data,
        input logic [debug_cmd_pkg::WORD_W-1:0] alu_result,
        input logic [debug_cmd_pkg::WORD_W-1:0] reg_addr,
        input logic [debug_cmd_pkg::WORD_W-1:0] reg_data,
        input logic [debug_cmd_pkg::WORD_W-1:0] pc
    );
        return {ctrl, mem_addr, mem_data, alu_result, reg_addr, reg_data, pc};
    endfunction

endpackage

/* hdl/pipe_snapshot_if.sv */
interface pipe_snapshot_if;

    logic [debug_cmd_pkg::WORD_W-1:0]   pc;              // IF/ID
    logic [debug_cmd_pkg::WORD_W-1:0]   reg_addr;        // IF/ID
    logic [debug_cmd_pkg::WORD_W-1:0]   reg_data;        // IF/ID
    logic [debug_cmd_pkg::WORD_W-1:0]   alu_result;      // EX/MEM
    logic [debug_cmd_pkg::WORD_W-1:0]   mem_data;        // MEM/WB
    logic [debug_cmd_pkg::WORD_W-1:0]   mem_addr;        // MEM/WB
    logic [pipe_snapshot_pkg::CTRL_W-1:0] ctrl;          // Packed control bits

    modport src (
        output pc, reg_addr, reg_data, alu_result, mem_data, mem_addr, ctrl
    );

    modport dst (
        input pc, reg_addr, reg_data, alu_result, mem_data, mem_addr, ctrl
    );

endinterface

/* hdl/debug_ctrl_fsm.sv */
module debug_ctrl_fsm (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic [debug_cmd_pkg::BYTE_W-1:0] i_rx_data,
    input  logic                             i_rx_done,
    input  logic                             i_end,          // Processor finished
    input  logic                             i_load_halt,    // Halt word seen
    input  logic                             i_dump_done,    // Last byte sent
    output logic                             o_load_en,
    output logic                             o_dump_go,
    output logic                             o_step,
    output logic                             o_start
);

    debug_cmd_pkg::ctrl_state_e state;
    debug_cmd_pkg::cmd_e        rx_cmd;
    logic                       dbg_ret;                     // Back to debug after dump

    assign rx_cmd    = debug_cmd_pkg::cmd_e'(i_rx_data);
    assign o_load_en = (state == debug_cmd_pkg::ST_LOAD);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= debug_cmd_pkg::ST_IDLE;
            dbg_ret   <= 1'b0;
            o_dump_go <= 1'b0;
            o_step    <= 1'b0;
            o_start   <= 1'b0;
        end else begin
            o_dump_go <= 1'b0;                               // Pulses by default
            o_step    <= 1'b0;
            case (state)
                debug_cmd_pkg::ST_IDLE: begin
                    if (i_rx_done) begin
                        case (rx_cmd)
                            debug_cmd_pkg::CMD_LOAD:  state <= debug_cmd_pkg::ST_LOAD;
                            debug_cmd_pkg::CMD_DEBUG: state <= debug_cmd_pkg::ST_DEBUG;
                            debug_cmd_pkg::CMD_RUN: begin
                                state   <= debug_cmd_pkg::ST_RUN;
                                o_start <= 1'b1;
                            end
                            default: state <= debug_cmd_pkg::ST_IDLE;  // Unknown byte
                        endcase
                    end
                end
                debug_cmd_pkg::ST_LOAD: begin
                    if (i_load_halt) begin
                        state <= debug_cmd_pkg::ST_IDLE;
                    end
                end
                debug_cmd_pkg::ST_DEBUG: begin
                    if (i_rx_done && rx_cmd == debug_cmd_pkg::CMD_STEP) begin
                        o_step    <= 1'b1;                   // Same cycle as dump_go
                        o_dump_go <= 1'b1;
                        dbg_ret   <= 1'b1;
                        state     <= debug_cmd_pkg::ST_DUMP;
                    end else if (i_rx_done && rx_cmd == debug_cmd_pkg::CMD_END_DEBUG) begin
                        o_dump_go <= 1'b1;                   // Final dump, no step
                        dbg_ret   <= 1'b0;
                        state     <= debug_cmd_pkg::ST_DUMP;
                    end
                end
                debug_cmd_pkg::ST_RUN: begin
                    if (i_end) begin
                        o_start   <= 1'b0;
                        o_dump_go <= 1'b1;
                        dbg_ret   <= 1'b0;
                        state     <= debug_cmd_pkg::ST_DUMP;
                    end
                end
                debug_cmd_pkg::ST_DUMP: begin
                    if (i_dump_done) begin
                        state <= dbg_ret ? debug_cmd_pkg::ST_DEBUG : debug_cmd_pkg::ST_IDLE;
                    end
                end
                default: state <= debug_cmd_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

/* hdl/instr_loader.sv */
module instr_loader #(
    parameter int MEM_ADDR_W = 32
) (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic                             i_load_en,
    input  logic [debug_cmd_pkg::BYTE_W-1:0] i_rx_data,
    input  logic                             i_rx_done,
    output logic [debug_cmd_pkg::WORD_W-1:0] o_instruction,
    output logic [MEM_ADDR_W-1:0]            o_instruction_address,
    output logic                             o_valid,
    output logic                             o_load_halt
);

    localparam int CNT_W = $clog2(debug_cmd_pkg::WORD_BYTES);

    logic [CNT_W-1:0]                 byte_cnt;
    logic                             word_last;         // Fourth byte arriving
    logic [debug_cmd_pkg::WORD_W-1:0] next_word;

    // First byte received ends up as the most significant one
    assign next_word = {o_instruction[debug_cmd_pkg::WORD_W-debug_cmd_pkg::BYTE_W-1:0],
                        i_rx_data};
    assign word_last = i_load_en && i_rx_done &&
                       (byte_cnt == CNT_W'(debug_cmd_pkg::WORD_BYTES - 1));

    always_ff @(posedge clk) begin
        if (i_load_en && i_rx_done) begin
            o_instruction <= next_word;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            byte_cnt              <= '0;
            o_instruction_address <= '0;
            o_valid               <= 1'b0;
            o_load_halt           <= 1'b0;
        end else begin
            o_valid     <= word_last && (next_word != debug_cmd_pkg::HALT_WORD);
            o_load_halt <= word_last && (next_word == debug_cmd_pkg::HALT_WORD);
            if (!i_load_en) begin
                byte_cnt              <= '0;             // Fresh start on next load
                o_instruction_address <= '0;
            end else begin
                if (i_rx_done) begin
                    byte_cnt <= byte_cnt + 1'b1;         // Wraps after the fourth byte
                end
                if (o_valid) begin
                    o_instruction_address <= o_instruction_address + MEM_ADDR_W'(4);
                end
            end
        end
    end

endmodule

/* hdl/snapshot_sender.sv */
module snapshot_sender (
    input  logic                             clk,
    input  logic                             i_rst_n,
    pipe_snapshot_if.dst                     snap,
    input  logic                             i_dump_go,
    input  logic                             i_tx_done,
    output logic                             o_tx_start,
    output logic [debug_cmd_pkg::BYTE_W-1:0] o_tx_data,
    output logic                             o_dump_done
);

    logic [pipe_snapshot_pkg::SNAP_W-1:0]     snap_q;        // Frozen pipeline state
    logic [pipe_snapshot_pkg::SNAP_CNT_W-1:0] byte_idx;      // Byte now on o_tx_data
    logic                                     busy;
    logic                                     last_byte;

    assign last_byte = (byte_idx ==
                        pipe_snapshot_pkg::SNAP_CNT_W'(pipe_snapshot_pkg::SNAP_BYTES - 1));

    // Byte stays put until the index moves with the next start pulse
    assign o_tx_data = snap_q[byte_idx * debug_cmd_pkg::BYTE_W +: debug_cmd_pkg::BYTE_W];

    always_ff @(posedge clk) begin
        if (i_dump_go && !busy) begin
            snap_q <= pipe_snapshot_pkg::pack_snapshot(snap.ctrl, snap.mem_addr,
                                                       snap.mem_data, snap.alu_result,
                                                       snap.reg_addr, snap.reg_data,
                                                       snap.pc);
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            byte_idx    <= '0;
            busy        <= 1'b0;
            o_tx_start  <= 1'b0;
            o_dump_done <= 1'b0;
        end else begin
            o_tx_start  <= 1'b0;
            o_dump_done <= 1'b0;
            if (!busy) begin
                if (i_dump_go) begin
                    busy       <= 1'b1;
                    byte_idx   <= '0;
                    o_tx_start <= 1'b1;                  // First byte needs no done
                end
            end else if (i_tx_done) begin
                if (last_byte) begin
                    busy        <= 1'b0;
                    o_dump_done <= 1'b1;
                end else begin
                    byte_idx   <= byte_idx + 1'b1;
                    o_tx_start <= 1'b1;
                end
            end
        end
    end

endmodule

/* hdl/debug_unit_top.sv */
module debug_unit_top #(
    parameter int MEM_ADDR_W = 32
) (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic [debug_cmd_pkg::BYTE_W-1:0] i_rx_data,
    input  logic                             i_rx_done,
    input  logic                             i_tx_done,
    input  logic                             i_end,
    input  logic [debug_cmd_pkg::WORD_W-1:0] i_pc,
    input  logic [debug_cmd_pkg::WORD_W-1:0] i_reg_addr,
    input  logic [debug_cmd_pkg::WORD_W-1:0] i_reg_data,
    input  logic [debug_cmd_pkg::WORD_W-1:0] i_alu_result,
    input  logic [debug_cmd_pkg::WORD_W-1:0] i_mem_data,
    input  logic [debug_cmd_pkg::WORD_W-1:0] i_mem_addr,
    input  logic                             i_jump,
    input  logic                             i_branch,
    input  logic                             i_reg_dst,
    input  logic                             i_mem_to_reg,
    input  logic                             i_mem_read,
    input  logic                             i_mem_write,
    input  logic                             i_imm_flag,
    input  logic                             i_sign_flag,
    input  logic                             i_reg_write,
    input  logic [1:0]                       i_alu_src,
    input  logic [1:0]                       i_width,
    input  logic [1:0]                       i_alu_op,
    output logic                             o_tx_start,
    output logic [debug_cmd_pkg::BYTE_W-1:0] o_tx_data,
    output logic [debug_cmd_pkg::WORD_W-1:0] o_instruction,
    output logic [MEM_ADDR_W-1:0]            o_instruction_address,
    output logic                             o_valid,
    output logic                             o_step,
    output logic                             o_start
);

    logic load_en;
    logic load_halt;
    logic dump_go;
    logic dump_done;

    pipe_snapshot_if snap_if ();

    // Source side of the snapshot bundle
    assign snap_if.pc         = i_pc;
    assign snap_if.reg_addr   = i_reg_addr;
    assign snap_if.reg_data   = i_reg_data;
    assign snap_if.alu_result = i_alu_result;
    assign snap_if.mem_data   = i_mem_data;
    assign snap_if.mem_addr   = i_mem_addr;
    assign snap_if.ctrl       = {1'b0, i_jump, i_branch, i_reg_dst, i_mem_to_reg,
                                 i_mem_read, i_mem_write, i_imm_flag, i_sign_flag,
                                 i_reg_write, i_alu_src, i_width, i_alu_op};  // Pad bit on top

    debug_ctrl_fsm ctrl_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_rx_data   (i_rx_data),
        .i_rx_done   (i_rx_done),
        .i_end       (i_end),
        .i_load_halt (load_halt),
        .i_dump_done (dump_done),
        .o_load_en   (load_en),
        .o_dump_go   (dump_go),
        .o_step      (o_step),
        .o_start     (o_start)
    );

    instr_loader #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) loader_i (
        .clk                   (clk),
        .i_rst_n               (i_rst_n),
        .i_load_en             (load_en),
        .i_rx_data             (i_rx_data),
        .i_rx_done             (i_rx_done),
        .o_instruction         (o_instruction),
        .o_instruction_address (o_instruction_address),
        .o_valid               (o_valid),
        .o_load_halt           (load_halt)
    );

    snapshot_sender sender_i (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .snap        (snap_if.dst),
        .i_dump_go   (dump_go),
        .i_tx_done   (i_tx_done),
        .o_tx_start  (o_tx_start),
        .o_tx_data   (o_tx_data),
        .o_dump_done (dump_done)
    );

endmodule

/* include/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Each row holds an operation and its data
//   BYTE rows carry the received byte in data[7:0]
//   WORD rows carry the address in data[63:32] and the instruction in data[31:0]
//   CHECK rows carry the o_start level in data[32] and below it the valid, step,
//   start and tx counts in 8 bits each
localparam logic [2:0] OP_BYTE   = 3'd0;
localparam logic [2:0] OP_END    = 3'd1;                 // One-cycle i_end
localparam logic [2:0] OP_FIELDS = 3'd2;                 // New random pipeline fields
localparam logic [2:0] OP_DUMP   = 3'd3;
localparam logic [2:0] OP_WORD   = 3'd4;
localparam logic [2:0] OP_CHECK  = 3'd5;                 // Compares pulse counts and ends a test

typedef struct packed {
    logic [2:0]  op;
    logic [63:0] data;
} vec_t;

localparam int N_VEC = 51;

localparam vec_t VECS [N_VEC] = '{
    '{OP_BYTE, 64'h01},                                  // Load
    '{OP_BYTE, 64'h8c}, '{OP_BYTE, 64'h01}, '{OP_BYTE, 64'h00}, '{OP_BYTE, 64'h04},
    '{OP_WORD, 64'h0000_0000_8c01_0004},
    '{OP_BYTE, 64'h20}, '{OP_BYTE, 64'h02}, '{OP_BYTE, 64'h00}, '{OP_BYTE, 64'h0a},
    '{OP_WORD, 64'h0000_0004_2002_000a},
    '{OP_BYTE, 64'hff}, '{OP_BYTE, 64'hff}, '{OP_BYTE, 64'hff}, '{OP_BYTE, 64'hff},
    '{OP_CHECK, 64'h0000_0000_0200_0000},
    '{OP_FIELDS, 64'h0}, '{OP_BYTE, 64'h04}, '{OP_END, 64'h0},  // Run
    '{OP_DUMP, 64'h0}, '{OP_CHECK, 64'h0000_0000_0000_011a},
    '{OP_BYTE, 64'h02}, '{OP_FIELDS, 64'h0}, '{OP_BYTE, 64'h08},  // Step twice
    '{OP_DUMP, 64'h0}, '{OP_FIELDS, 64'h0}, '{OP_BYTE, 64'h08},
    '{OP_DUMP, 64'h0}, '{OP_CHECK, 64'h0000_0000_0002_0034},
    '{OP_BYTE, 64'h10}, '{OP_DUMP, 64'h0}, '{OP_BYTE, 64'h01},  // End debug and load again
    '{OP_BYTE, 64'h00}, '{OP_BYTE, 64'h22}, '{OP_BYTE, 64'h18}, '{OP_BYTE, 64'h20},
    '{OP_WORD, 64'h0000_0000_0022_1820},
    '{OP_BYTE, 64'hff}, '{OP_BYTE, 64'hff}, '{OP_BYTE, 64'hff}, '{OP_BYTE, 64'hff},
    '{OP_CHECK, 64'h0000_0000_0100_001a},
    '{OP_BYTE, 64'h55}, '{OP_CHECK, 64'h0},              // Unknown byte in idle
    '{OP_BYTE, 64'h04}, '{OP_BYTE, 64'h01}, '{OP_BYTE, 64'h08},  // Bytes during a run
    '{OP_BYTE, 64'h02}, '{OP_END, 64'h0},
    '{OP_DUMP, 64'h0}, '{OP_CHECK, 64'h0000_0000_0000_011a}
};

`endif

/* test/tb_debug_unit.sv */
module tb_debug_unit;

    `include "tb_vectors.svh"

    logic clk;
    logic i_rst_n, i_rx_done, i_end, i_jump, i_branch, i_reg_dst, i_mem_to_reg;
    logic i_tx_done = 1'b0;
    logic i_mem_read, i_mem_write, i_imm_flag, i_sign_flag, i_reg_write;
    logic [1:0] i_alu_src, i_width, i_alu_op;
    logic [7:0] i_rx_data, o_tx_data, tx_byte;
    logic [31:0] i_pc, i_reg_addr, i_reg_data, i_alu_result, i_mem_data, i_mem_addr;
    logic [31:0] f_pc, f_reg_addr, f_reg_data, f_alu_result, f_mem_data, f_mem_addr;
    logic [14:0] f_ctrl;                                 // Control bits with jump on top
    logic [31:0] o_instruction, o_instruction_address;
    logic o_tx_start, o_valid, o_step, o_start, start_q = 1'b0;
    logic [7:0] tx_q [$];                                // Bytes of the current dump
    logic [63:0] valid_q [$];                            // {address, word} per o_valid
    int errors = 0, err_base = 0, test_no = 0, cycle_cnt = 0, cycle_limit = 0;
    int n_valid = 0, n_step = 0, n_start = 0, n_tx = 0, tx_wait = 0, tx_dones = 0;

    debug_unit_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("MISMATCH t=%0t %s expected %0h got %0h", $time, name, exp, act);
        errors++;
    endtask

    task automatic set_fields();
        f_pc = $urandom;
        f_reg_addr = $urandom;
        f_reg_data = $urandom;
        f_alu_result = $urandom;
        f_mem_data = $urandom;
        f_mem_addr = $urandom;
        f_ctrl = 15'($urandom);
        i_pc <= f_pc;
        i_reg_addr <= f_reg_addr;
        i_reg_data <= f_reg_data;
        i_alu_result <= f_alu_result;
        i_mem_data <= f_mem_data;
        i_mem_addr <= f_mem_addr;
        {i_jump, i_branch, i_reg_dst, i_mem_to_reg, i_mem_read, i_mem_write, i_imm_flag,
         i_sign_flag, i_reg_write, i_alu_src, i_width, i_alu_op} <= f_ctrl;
    endtask

    task automatic send_byte(input logic [7:0] b);
        int gap;
        gap = 2 + int'($urandom % 3);                    // Idle cycles after the strobe
        @(posedge clk);
        i_rx_data <= b;
        i_rx_done <= 1'b1;
        @(posedge clk);
        i_rx_done <= 1'b0;
        repeat (gap) @(posedge clk);
    endtask

    task automatic raise_end();
        @(posedge clk);
        if (o_start !== 1'b1) begin
            $display("o_start was low before i_end at t=%0t", $time);
            errors++;
        end
        i_end <= 1'b1;
        @(posedge clk);
        i_end <= 1'b0;
    endtask

    task automatic check_dump();
        logic [pipe_snapshot_pkg::SNAP_W-1:0] exp;
        // Control on top and the PC at the bottom with the low byte first
        exp = {1'b0, f_ctrl, f_mem_addr, f_mem_data, f_alu_result, f_reg_addr, f_reg_data,
               f_pc};
        do @(negedge clk); while (tx_q.size() == 0);
        @(posedge clk);
        set_fields();                                    // Snapshot must already be frozen
        do @(negedge clk); while (tx_dones < pipe_snapshot_pkg::SNAP_BYTES);
        repeat (2) @(negedge clk);
        if (tx_q.size() != pipe_snapshot_pkg::SNAP_BYTES) begin
            $display("dump before t=%0t had %0d bytes instead of %0d", $time, tx_q.size(),
                     pipe_snapshot_pkg::SNAP_BYTES);
            errors++;
        end
        for (int i = 0; i < tx_q.size() && i < pipe_snapshot_pkg::SNAP_BYTES; i++) begin
            if (tx_q[i] !== exp[i*8 +: 8]) begin
                report_mismatch($sformatf("o_tx_data[%0d]", i), 32'(exp[i*8 +: 8]),
                                32'(tx_q[i]));
            end
        end
        tx_q.delete();
        tx_dones = 0;
    endtask

    task automatic check_word(input logic [31:0] addr, input logic [31:0] word);
        logic [63:0] got;
        do @(negedge clk); while (valid_q.size() == 0);
        got = valid_q.pop_front();
        if (got[63:32] !== addr) begin
            report_mismatch("o_instruction_address", addr, got[63:32]);
        end
        if (got[31:0] !== word) begin
            report_mismatch("o_instruction", word, got[31:0]);
        end
    endtask

    task automatic check_counts(input logic [63:0] d);
        @(negedge clk);
        if (n_valid != int'(d[31:24])) report_mismatch("o_valid pulses", 32'(d[31:24]), n_valid);
        if (n_step != int'(d[23:16])) report_mismatch("o_step pulses", 32'(d[23:16]), n_step);
        if (n_start != int'(d[15:8])) report_mismatch("o_start rises", 32'(d[15:8]), n_start);
        if (n_tx != int'(d[7:0])) report_mismatch("o_tx_start pulses", 32'(d[7:0]), n_tx);
        if (o_start !== d[32]) report_mismatch("o_start", 32'(d[32]), 32'(o_start));
        test_no++;
        $display("test %0d done with %0d errors", test_no, errors - err_base);
        err_base = errors;
        n_valid = 0;
        n_step = 0;
        n_start = 0;
        n_tx = 0;
        valid_q.delete();
    endtask

    function automatic int worst_cycles(input logic [2:0] op);
        case (op)
            OP_BYTE: return 8;
            OP_DUMP: return 240;                         // 26 bytes of up to 9 cycles each
            default: return 2;
        endcase
    endfunction

    // Output monitor
    always @(posedge clk) begin
        if (o_valid) begin
            n_valid++;
            valid_q.push_back({o_instruction_address, o_instruction});
        end
        if (o_step) n_step++;
        if (o_start && !start_q) n_start++;
        start_q = o_start;
    end

    // UART transmitter answering after 1 to 6 random cycles
    always @(posedge clk) begin
        i_tx_done <= 1'b0;
        if (tx_wait > 0) begin
            if (o_tx_start) begin
                $display("o_tx_start while a byte was still pending at t=%0t", $time);
                errors++;
            end
            if (o_tx_data !== tx_byte) report_mismatch("o_tx_data", 32'(tx_byte), 32'(o_tx_data));
            tx_wait--;
            if (tx_wait == 0) begin
                i_tx_done <= 1'b1;
                tx_dones++;
            end
        end else if (o_tx_start) begin
            tx_byte = o_tx_data;
            tx_q.push_back(o_tx_data);
            n_tx++;
            tx_wait = 1 + int'($urandom % 6);
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles, controller in %s", cycle_cnt,
                     dut_i.ctrl_i.state.name());
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hb2fdfeae));
        i_rst_n <= 1'b0;
        i_rx_data <= '0;
        i_rx_done <= 1'b0;
        i_end <= 1'b0;
        set_fields();
        for (int i = 0; i < N_VEC; i++) begin
            cycle_limit = cycle_limit + 2 * worst_cycles(VECS[i].op);
        end
        repeat (2) @(posedge clk);
        i_rst_n <= 1'b1;
        for (int i = 0; i < N_VEC; i++) begin
            case (VECS[i].op)
                OP_BYTE: send_byte(VECS[i].data[7:0]);
                OP_END: raise_end();
                OP_FIELDS: begin
                    @(posedge clk);
                    set_fields();
                end
                OP_DUMP: check_dump();
                OP_WORD: check_word(VECS[i].data[63:32], VECS[i].data[31:0]);
                default: check_counts(VECS[i].data);
            endcase
        end
        $display("%0d tests run, %0d errors", test_no, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
hdl/debug_cmd_pkg.sv
hdl/pipe_snapshot_pkg.sv
hdl/pipe_snapshot_if.sv
hdl/debug_ctrl_fsm.sv
hdl/instr_loader.sv
hdl/snapshot_sender.sv
hdl/debug_unit_top.sv
test/tb_debug_unit.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_debug_unit -f sim.f -Mdir obj_dir
obj_dir/Vtb_debug_unit > sim.log
cat sim.log

if grep -qx "No errors" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
